// File: tests/blocfifo_input.txt
# op a1 a2 used (hex)  1 mode a1, 2 write a1 blocks, 3 read a1 packets profile a2
# 4 drop after a1 words profile a2, 5 overflow probe, 6 underflow probe, 7 reset
1 1 0 0
2 2 0 2
3 4 0 2
7 0 0 0
1 0 0 0
2 2 0 2
3 1 0 1
3 1 0 0
6 0 0 0
2 1 0 1
3 1 1 0
2 4 0 4
5 0 0 4
3 4 0 0
2 2 0 2
4 5 0 1
3 1 0 0

// File: filelist.f
hdl/blocfifo_pkg.sv
hdl/mem_port_if.sv
hdl/bloc_ctrl.sv
hdl/wr_addr_gen.sv
hdl/seg_rd_addr_gen.sv
hdl/bloc_mem.sv
hdl/dout_pipe.sv
hdl/blocfifo_top.sv
tests/blocfifo_assert.sv
tests/tb_blocfifo.sv

// File: run_sim.sh
#!/bin/sh
# build and run the block FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_blocfifo -f filelist.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_blocfifo > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tests/tb_blocfifo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_blocfifo import blocfifo_pkg::*; ();

  localparam int BLK_LEN = BLOCK_LEN_DEF;
  localparam int BLK_QTY = BLOCK_QTY_DEF;
  localparam int LAT     = LATENCY_RD_DEF;

  logic                  clk_rd;
  logic                  rst_n;
  bloc_mode_e            mode_sel;
  logic                  din_valid;
  logic [DATA_WIDTH-1:0] din_data;
  logic [PROF_WIDTH-1:0] prof_sel;
  logic                  dout_drop;
  logic                  dout_request;
  logic                  din_ready;
  logic                  dout_valid;
  logic                  dout_sop;
  logic                  dout_eop;
  logic [DATA_WIDTH-1:0] dout_data;
  logic [INDX_WIDTH-1:0] dout_index;
  logic [USED_WIDTH-1:0] bloc_used;
  logic                  bloc_full;
  logic                  bloc_empty;
  logic                  overflow;
  logic                  underflow;

  integer seed = 32'hed96_3d18;
  logic [DATA_WIDTH-1:0] ref_mem [BLK_QTY][BLK_LEN];  // model of stored blocks
  int wr_blk;     // model write block
  int rd_blk;     // model read block
  int hold_cnt;   // blocks written, saturating
  bit mode_hold;
  logic [14:0] out_q [$];  // {sop, eop, index, data} per output word
  int cmd_op [$];
  int cmd_a1 [$];
  int cmd_a2 [$];
  int cmd_used [$];  // expected bloc_used after the command
  int err_cnt;
  int chk_cnt;
  int cyc_cnt;
  int cyc_limit;

  blocfifo_top #(.BLOCK_LEN(BLK_LEN), .BLOCK_QTY(BLK_QTY), .LATENCY_RD(LAT))
    blocfifo_top_inst (.*);

  initial begin
    clk_rd = 1'b0;
    forever #20 clk_rd = ~clk_rd;  // 40 ns period
  end

  // outputs settle well before the falling edge
  always @(negedge clk_rd) begin
    if (rst_n && dout_valid) begin
      out_q.push_back({dout_sop, dout_eop, dout_index, dout_data});
    end
  end

  always @(posedge clk_rd) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
      $display("timeout: run did not finish within %0d cycles", cyc_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic next_cycle;
    @(posedge clk_rd);
    #2;  // drive clear of the edge
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // read order inside a block for each profile
  function automatic int offset_at(input int prof, input int k);
    if (prof == 0) return k;
    if (k < 8) return 8 + k;
    return 23 - k;
  endfunction

  function automatic int packet_len(input int prof);
    return (prof == 0) ? 16 : 24;
  endfunction

  task automatic load_commands;
    int    fd;
    int    code;
    int    f0;
    int    f1;
    int    f2;
    int    f3;
    string line;
    fd = $fopen("tests/blocfifo_input.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open the stimulus file tests/blocfifo_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0 && line[0] != "#") begin  // skip notes
        if ($sscanf(line, "%h %h %h %h", f0, f1, f2, f3) == 4) begin
          cmd_op.push_back(f0);
          cmd_a1.push_back(f1);
          cmd_a2.push_back(f2);
          cmd_used.push_back(f3);
        end
      end
    end
    $fclose(fd);
    if (cmd_op.size() == 0) begin
      err_cnt++;
      $display("the stimulus file holds no commands");
    end
  endtask

  task automatic apply_reset;
    rst_n = 1'b0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
    wr_blk = 0;
    rd_blk = 0;
    hold_cnt = 0;
    out_q.delete();
    next_cycle();
  endtask

  task automatic check_levels(input int used);
    compare_value("bloc_used", 32'(bloc_used), 32'(used));
    compare_value("bloc_full", 32'(bloc_full), 32'(used == BLK_QTY));
    compare_value("bloc_empty", 32'(bloc_empty), 32'(used == 0));
    compare_value("din_ready", 32'(din_ready), 32'(used < BLK_QTY));
  endtask

  task automatic write_blocks(input int n);
    int rnd;
    for (int b = 0; b < n; b++) begin
      for (int w = 0; w < BLK_LEN; w++) begin
        din_valid = 1'b0;
        while (!din_ready) next_cycle();  // back-pressure between blocks
        rnd = $random(seed);
        din_valid = 1'b1;
        din_data = rnd[DATA_WIDTH-1:0];
        ref_mem[wr_blk][w] = rnd[DATA_WIDTH-1:0];
        next_cycle();
      end
      wr_blk = (wr_blk + 1) % BLK_QTY;
      if (hold_cnt < BLK_QTY) hold_cnt++;
    end
    din_valid = 1'b0;
  endtask

  task automatic read_packet(input int prof, input int n_words, input bit drop);
    logic [14:0] ent;
    prof_sel = PROF_WIDTH'(prof);
    for (int k = 0; k < n_words; k++) begin
      dout_request = 1'b1;
      dout_drop = drop && (k == n_words - 1);  // abandon on the last request
      next_cycle();
    end
    dout_request = 1'b0;
    dout_drop = 1'b0;
    while (out_q.size() < n_words) next_cycle();
    repeat (LAT) next_cycle();  // a stray word would land here
    compare_value("word_count", 32'(out_q.size()), 32'(n_words));
    for (int k = 0; k < n_words && k < out_q.size(); k++) begin
      ent = out_q[k];
      compare_value("dout_data", 32'(ent[7:0]),
                    32'(ref_mem[rd_blk][offset_at(prof, k)]));
      compare_value("dout_index", 32'(ent[12:8]), 32'(k));
      compare_value("dout_sop", 32'(ent[14]), 32'(k == 0));
      compare_value("dout_eop", 32'(ent[13]), 32'(k == n_words - 1));
    end
    out_q.delete();
    if (mode_hold && rd_blk + 1 >= hold_cnt) rd_blk = 0;  // hold loops back
    else rd_blk = (rd_blk + 1) % BLK_QTY;
  endtask

  task automatic probe_overflow;
    int rnd;
    rnd = $random(seed);
    din_valid = 1'b1;
    din_data = rnd[DATA_WIDTH-1:0];  // dropped word stays out of the model
    next_cycle();
    din_valid = 1'b0;
    compare_value("overflow", 32'(overflow), 32'd1);
    next_cycle();
    compare_value("overflow", 32'(overflow), 32'd0);
  endtask

  task automatic probe_underflow;
    dout_request = 1'b1;
    next_cycle();
    dout_request = 1'b0;
    compare_value("underflow", 32'(underflow), 32'd1);
    next_cycle();
    compare_value("underflow", 32'(underflow), 32'd0);
    repeat (LAT) next_cycle();
    compare_value("dout_valid_count", 32'(out_q.size()), 32'd0);
  endtask

  task automatic run_command(input int op, input int a1, input int a2);
    case (op)
      1: begin
        mode_sel = bloc_mode_e'(a1[0]);
        mode_hold = a1[0];
        next_cycle();
      end
      2: write_blocks(a1);
      3: for (int p = 0; p < a1; p++) read_packet(a2, packet_len(a2), 1'b0);
      4: read_packet(a2, a1, 1'b1);
      5: probe_overflow();
      6: probe_underflow();
      7: apply_reset();
      default: begin
        err_cnt++;
        $display("unknown command code %0d in the stimulus file", op);
      end
    endcase
  endtask

  initial begin
    rst_n = 1'b0;
    mode_sel = MODE_CLEAR;
    din_valid = 1'b0;
    din_data = '0;
    prof_sel = '0;
    dout_drop = 1'b0;
    dout_request = 1'b0;
    load_commands();
    cyc_limit = cmd_op.size() * 64;
    apply_reset();
    foreach (cmd_op[i]) begin
      run_command(cmd_op[i], cmd_a1[i], cmd_a2[i]);
      check_levels(cmd_used[i]);
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/blocfifo_assert.sv
`timescale 1ns/10ps
`default_nettype none

module blocfifo_assert import blocfifo_pkg::*; (
  input wire                  clk_rd,
  input wire                  rst_n,
  input wire                  din_valid,
  input wire                  din_ready,
  input wire                  dout_request,
  input wire [USED_WIDTH-1:0] bloc_used,
  input wire                  dout_valid,
  input wire                  dout_sop,
  input wire                  dout_eop,
  input wire                  bloc_full,
  input wire                  bloc_empty,
  input wire                  overflow,
  input wire                  underflow
);

  marker_with_valid: assert property (@(posedge clk_rd) disable iff (!rst_n)
    (dout_sop || dout_eop) |-> dout_valid)
    else $error("packet marker without dout_valid");

  overflow_cause: assert property (@(posedge clk_rd) disable iff (!rst_n)
    overflow |-> $past(din_valid && !din_ready))  // word offered while full
    else $error("overflow without a refused write");

  underflow_cause: assert property (@(posedge clk_rd) disable iff (!rst_n)
    underflow |-> $past(dout_request && bloc_used == '0))
    else $error("underflow without a request on empty");

  full_empty_apart: assert property (@(posedge clk_rd) disable iff (!rst_n)
    !(bloc_full && bloc_empty))
    else $error("full and empty high together");

endmodule

bind blocfifo_top blocfifo_assert blocfifo_assert_inst (.*);

`default_nettype wire

// File: hdl/blocfifo_top.sv
`timescale 1ns/10ps
`default_nettype none

module blocfifo_top import blocfifo_pkg::*; #(
  parameter int BLOCK_LEN  = BLOCK_LEN_DEF,
  parameter int BLOCK_QTY  = BLOCK_QTY_DEF,
  parameter int LATENCY_RD = LATENCY_RD_DEF
) (
  input  wire                   clk_rd,
  input  wire                   rst_n,
  input  wire bloc_mode_e       mode_sel,     // clear or hold
  input  wire                   din_valid,
  input  wire [DATA_WIDTH-1:0]  din_data,
  input  wire [PROF_WIDTH-1:0]  prof_sel,     // read profile
  input  wire                   dout_drop,    // abandon current block
  input  wire                   dout_request,
  output logic                  din_ready,
  output logic                  dout_valid,
  output logic                  dout_sop,
  output logic                  dout_eop,
  output logic [DATA_WIDTH-1:0] dout_data,
  output logic [INDX_WIDTH-1:0] dout_index,
  output logic [USED_WIDTH-1:0] bloc_used,
  output logic                  bloc_full,
  output logic                  bloc_empty,
  output logic                  overflow,
  output logic                  underflow
);

  logic [WORD_WIDTH-1:0] wr_base;
  logic [WORD_WIDTH-1:0] rd_base;
  logic                  rd_allow;
  logic                  drop_take;
  logic                  block_done;
  logic                  rd_last;
  logic                  rd_sop;
  logic                  rd_eop;

  mem_port_if mp_if ();

  bloc_ctrl #(.BLOCK_LEN(BLOCK_LEN), .BLOCK_QTY(BLOCK_QTY)) u_ctrl (
    .clk_rd, .rst_n, .mode_sel, .din_valid, .dout_request, .dout_drop,
    .block_done, .rd_last, .din_ready, .wr_base, .rd_base, .rd_allow,
    .drop_take, .bloc_used, .bloc_full, .bloc_empty, .overflow, .underflow
  );

  wr_addr_gen #(.BLOCK_LEN(BLOCK_LEN)) u_wr (
    .clk_rd, .rst_n, .din_valid, .din_ready, .din_data, .wr_base,
    .block_done, .mp(mp_if.wr_src)
  );

  seg_rd_addr_gen u_rd (
    .clk_rd, .rst_n, .prof_sel, .dout_request, .rd_allow, .drop_take,
    .rd_base, .rd_last, .rd_eop, .rd_sop, .mp(mp_if.rd_src)
  );

  bloc_mem #(.BLOCK_LEN(BLOCK_LEN), .BLOCK_QTY(BLOCK_QTY), .LATENCY_RD(LATENCY_RD)) u_mem (
    .clk_rd, .mp(mp_if.mem)
  );

  dout_pipe #(.LATENCY_RD(LATENCY_RD)) u_dout (
    .clk_rd, .rst_n, .rd_en_in(mp_if.rd_en), .rd_sop, .rd_eop,
    .mp(mp_if.rd_sink), .dout_valid, .dout_sop, .dout_eop, .dout_data,
    .dout_index
  );

endmodule

`default_nettype wire

// File: hdl/dout_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module dout_pipe import blocfifo_pkg::*; #(
  parameter int LATENCY_RD = LATENCY_RD_DEF
) (
  input  wire                   clk_rd,
  input  wire                   rst_n,
  input  wire                   rd_en_in,
  input  wire                   rd_sop,
  input  wire                   rd_eop,
  mem_port_if.rd_sink           mp,
  output logic                  dout_valid,
  output logic                  dout_sop,
  output logic                  dout_eop,
  output logic [DATA_WIDTH-1:0] dout_data,
  output logic [INDX_WIDTH-1:0] dout_index
);

  logic [LATENCY_RD-1:0] vld_sr;  // same depth as the memory read
  logic [LATENCY_RD-1:0] sop_sr;
  logic [LATENCY_RD-1:0] eop_sr;
  logic [INDX_WIDTH-1:0] idx_cnt;

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
      sop_sr <= '0;
      eop_sr <= '0;
    end else begin
      vld_sr[0] <= rd_en_in;
      sop_sr[0] <= rd_sop;
      eop_sr[0] <= rd_eop;
      for (int i = 1; i < LATENCY_RD; i++) begin
        vld_sr[i] <= vld_sr[i-1];
        sop_sr[i] <= sop_sr[i-1];
        eop_sr[i] <= eop_sr[i-1];
      end
    end
  end

  assign dout_valid = vld_sr[LATENCY_RD-1];
  assign dout_sop   = sop_sr[LATENCY_RD-1];
  assign dout_eop   = eop_sr[LATENCY_RD-1];
  assign dout_data  = mp.rd_data;  // already aligned by the memory pipe

  // sop forces 0 in case a drop between reads left no eop behind
  assign dout_index = dout_sop ? '0 : idx_cnt;

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      idx_cnt <= '0;
    end else if (dout_eop) begin
      idx_cnt <= '0;
    end else if (dout_valid) begin
      idx_cnt <= dout_index + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bloc_mem.sv
`timescale 1ns/10ps
`default_nettype none

module bloc_mem import blocfifo_pkg::*; #(
  parameter int BLOCK_LEN  = BLOCK_LEN_DEF,
  parameter int BLOCK_QTY  = BLOCK_QTY_DEF,
  parameter int LATENCY_RD = LATENCY_RD_DEF
) (
  input  wire         clk_rd,
  mem_port_if.mem     mp
);

  localparam int DEPTH = BLOCK_LEN * BLOCK_QTY;

  logic [DATA_WIDTH-1:0] mem_arr [DEPTH];       // block ring storage
  logic [DATA_WIDTH-1:0] rd_pipe [LATENCY_RD];  // read stages

  always_ff @(posedge clk_rd) begin
    if (mp.wr_en) begin
      mem_arr[mp.wr_addr] <= mp.wr_data;
    end
  end

  always_ff @(posedge clk_rd) begin
    if (mp.rd_en) begin
      rd_pipe[0] <= mem_arr[mp.rd_addr];  // array read stage
    end
    for (int i = 1; i < LATENCY_RD; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mp.rd_data = rd_pipe[LATENCY_RD-1];

endmodule

`default_nettype wire

// File: hdl/seg_rd_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module seg_rd_addr_gen import blocfifo_pkg::*; (
  input  wire                   clk_rd,
  input  wire                   rst_n,
  input  wire [PROF_WIDTH-1:0]  prof_sel,
  input  wire                   dout_request,
  input  wire                   rd_allow,
  input  wire                   drop_take,
  input  wire [WORD_WIDTH-1:0]  rd_base,
  output logic                  rd_last,
  output logic                  rd_eop,
  output logic                  rd_sop,
  mem_port_if.rd_src            mp
);

  logic                  in_pkt;    // walk has left the profile start
  logic [SEGM_WIDTH-1:0] segm;      // segment once inside a packet
  logic [OFFS_WIDTH-1:0] offs;      // offset once inside a packet
  logic [SEGM_WIDTH-1:0] cur_segm;
  logic [OFFS_WIDTH-1:0] cur_offs;
  logic [SEGM_WIDTH-1:0] nxt_segm;
  logic                  seg_end;
  logic                  last_segm;
  logic                  rd_en;

  // outside a packet the walk sits at the start of the selected profile
  assign cur_segm  = in_pkt ? segm : '0;
  assign cur_offs  = in_pkt ? offs : SEGM_START[prof_sel][0];
  assign nxt_segm  = cur_segm + 1'b1;

  assign seg_end   = cur_offs == SEGM_END[prof_sel][cur_segm];
  assign last_segm = cur_segm == SEGM_WIDTH'(SEGMENT_QTY - 1);

  assign rd_en     = dout_request & rd_allow;
  assign rd_last   = rd_en & seg_end & last_segm;
  assign rd_sop    = rd_en & ~in_pkt;             // first offset of segment 0
  assign rd_eop    = rd_last | (drop_take & rd_en);

  assign mp.rd_en   = rd_en;
  assign mp.rd_addr = rd_base + WORD_WIDTH'(cur_offs);

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      in_pkt <= 1'b0;
      segm   <= '0;
      offs   <= '0;
    end else if (rd_last | drop_take) begin
      in_pkt <= 1'b0;  // back to profile start
      segm   <= '0;
    end else if (rd_en) begin
      in_pkt <= 1'b1;
      if (seg_end) begin
        segm <= nxt_segm;
        offs <= SEGM_START[prof_sel][nxt_segm];  // jump to next segment
      end else if (SEGM_STEP[prof_sel][cur_segm] == STEP_DOWN) begin
        segm <= cur_segm;
        offs <= cur_offs - 1'b1;
      end else begin
        segm <= cur_segm;
        offs <= cur_offs + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/wr_addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module wr_addr_gen import blocfifo_pkg::*; #(
  parameter int BLOCK_LEN = BLOCK_LEN_DEF
) (
  input  wire                   clk_rd,
  input  wire                   rst_n,
  input  wire                   din_valid,
  input  wire                   din_ready,
  input  wire [DATA_WIDTH-1:0]  din_data,
  input  wire [WORD_WIDTH-1:0]  wr_base,
  output logic                  block_done,
  mem_port_if.wr_src            mp
);

  logic [OFFS_WIDTH-1:0] wr_offs;  // next offset to write
  logic                  wr_take;

  assign wr_take    = din_valid & din_ready;  // accepted word
  assign block_done = wr_take & (wr_offs == OFFS_WIDTH'(BLOCK_LEN - 1));

  assign mp.wr_en   = wr_take;
  assign mp.wr_addr = wr_base + WORD_WIDTH'(wr_offs);
  assign mp.wr_data = din_data;

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      wr_offs <= '0;
    end else if (block_done) begin
      wr_offs <= '0;  // next block starts at offset 0
    end else if (wr_take) begin
      wr_offs <= wr_offs + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bloc_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bloc_ctrl import blocfifo_pkg::*; #(
  parameter int BLOCK_LEN = BLOCK_LEN_DEF,
  parameter int BLOCK_QTY = BLOCK_QTY_DEF
) (
  input  wire                    clk_rd,
  input  wire                    rst_n,
  input  wire bloc_mode_e        mode_sel,
  input  wire                    din_valid,
  input  wire                    dout_request,
  input  wire                    dout_drop,
  input  wire                    block_done,    // last word of a block written
  input  wire                    rd_last,       // last offset of a packet read
  output logic                   din_ready,
  output logic [WORD_WIDTH-1:0]  wr_base,
  output logic [WORD_WIDTH-1:0]  rd_base,
  output logic                   rd_allow,
  output logic                   drop_take,
  output logic [USED_WIDTH-1:0]  bloc_used,
  output logic                   bloc_full,
  output logic                   bloc_empty,
  output logic                   overflow,
  output logic                   underflow
);

  logic [BLOC_WIDTH-1:0] wr_bloc;   // block being written
  logic [BLOC_WIDTH-1:0] rd_bloc;   // block being read
  logic                  wr_wrap;   // toggles per write lap
  logic                  rd_wrap;   // toggles per read lap
  logic [USED_WIDTH-1:0] hold_cnt;  // blocks written, saturating
  logic [USED_WIDTH-1:0] ring_used;
  logic [BLOC_WIDTH-1:0] rd_next;
  logic                  wr_at_end;
  logic                  rd_at_end;
  logic                  rd_to_zero;
  logic                  rd_step;

  // differing lap bits put the write pointer one lap ahead
  assign ring_used = USED_WIDTH'(wr_bloc) - USED_WIDTH'(rd_bloc)
                   + ((wr_wrap ^ rd_wrap) ? USED_WIDTH'(BLOCK_QTY) : '0);

  assign bloc_used  = (mode_sel == MODE_HOLD) ? hold_cnt : ring_used;
  assign bloc_full  = bloc_used == USED_WIDTH'(BLOCK_QTY);
  assign bloc_empty = bloc_used == '0;
  assign din_ready  = bloc_used < USED_WIDTH'(BLOCK_QTY);
  assign rd_allow   = bloc_used != '0;
  assign drop_take  = dout_drop & rd_allow;  // drop only counts with data

  assign wr_at_end  = wr_bloc == BLOC_WIDTH'(BLOCK_QTY - 1);
  assign rd_at_end  = rd_bloc == BLOC_WIDTH'(BLOCK_QTY - 1);
  // hold mode loops back after the last written block
  assign rd_to_zero = rd_at_end
                    | ((mode_sel == MODE_HOLD)
                       & (USED_WIDTH'(rd_bloc) + USED_WIDTH'(1) >= hold_cnt));
  assign rd_next    = rd_to_zero ? '0 : rd_bloc + 1'b1;
  assign rd_step    = rd_last | drop_take;

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      wr_bloc  <= '0;
      wr_base  <= '0;
      wr_wrap  <= 1'b0;
      hold_cnt <= '0;
    end else if (block_done) begin
      wr_bloc  <= wr_at_end ? '0 : wr_bloc + 1'b1;
      wr_base  <= wr_at_end ? '0 : wr_base + WORD_WIDTH'(BLOCK_LEN);
      wr_wrap  <= wr_wrap ^ wr_at_end;
      if (hold_cnt != USED_WIDTH'(BLOCK_QTY)) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      rd_bloc <= '0;
      rd_base <= '0;
      rd_wrap <= 1'b0;
    end else if (rd_step) begin
      rd_bloc <= rd_next;
      rd_base <= rd_to_zero ? '0 : rd_base + WORD_WIDTH'(BLOCK_LEN);
      if (mode_sel == MODE_HOLD) begin
        rd_wrap <= wr_wrap ^ (rd_next > wr_bloc);  // keep lap consistent for clear mode
      end else begin
        rd_wrap <= rd_wrap ^ rd_at_end;
      end
    end
  end

  // one-cycle flow error pulses
  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      overflow  <= din_valid & ~din_ready;
      underflow <= dout_request & ~rd_allow;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mem_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if import blocfifo_pkg::*; ();

  logic                  wr_en;    // word written this cycle
  logic [WORD_WIDTH-1:0] wr_addr;  // base + write offset
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;    // read issued this cycle
  logic [WORD_WIDTH-1:0] rd_addr;  // base + profile offset
  logic [DATA_WIDTH-1:0] rd_data;  // valid LATENCY_RD after rd_en

  modport wr_src  (output wr_en, output wr_addr, output wr_data);
  modport rd_src  (output rd_en, output rd_addr);
  modport mem     (input wr_en, input wr_addr, input wr_data,
                   input rd_en, input rd_addr, output rd_data);
  modport rd_sink (input rd_data);

endinterface

`default_nettype wire

// File: hdl/blocfifo_pkg.sv
`default_nettype none

package blocfifo_pkg;

  parameter int DATA_WIDTH     = 8;   // word width on both sides
  parameter int BLOCK_LEN_DEF  = 16;  // words per block
  parameter int BLOCK_QTY_DEF  = 4;   // blocks in the ring
  parameter int LATENCY_RD_DEF = 2;   // cycles from rd_en to rd_data

  parameter int OFFS_WIDTH  = 4;  // offset within a block
  parameter int BLOC_WIDTH  = 2;  // block number
  parameter int USED_WIDTH  = 3;  // must hold BLOCK_QTY itself
  parameter int WORD_WIDTH  = 6;  // flat word address
  parameter int INDX_WIDTH  = 5;  // longest packet is 24 words

  parameter int SEGMENT_QTY = 2;  // segments per profile
  parameter int PROFILE_QTY = 2;  // selectable profiles
  parameter int SEGM_WIDTH  = 1;  // segment number
  parameter int PROF_WIDTH  = 1;  // prof_sel width

  typedef enum logic {
    MODE_CLEAR = 1'b0,  // read once, then free
    MODE_HOLD  = 1'b1   // replay written blocks in a loop
  } bloc_mode_e;

  typedef enum logic {
    STEP_UP   = 1'b0,  // offset +1
    STEP_DOWN = 1'b1   // offset -1
  } step_dir_e;

  // profile 0 is a plain 0..15 sweep split in halves
  // profile 1 is the upper half, then the whole block backwards
  parameter logic [OFFS_WIDTH-1:0] SEGM_START [PROFILE_QTY][SEGMENT_QTY] = '{
    '{4'd0, 4'd8},
    '{4'd8, 4'd15}
  };

  parameter logic [OFFS_WIDTH-1:0] SEGM_END [PROFILE_QTY][SEGMENT_QTY] = '{
    '{4'd7,  4'd15},
    '{4'd15, 4'd0}
  };

  parameter step_dir_e SEGM_STEP [PROFILE_QTY][SEGMENT_QTY] = '{
    '{STEP_UP, STEP_UP},
    '{STEP_UP, STEP_DOWN}
  };

endpackage

`default_nettype wire
